// File: source/shim_consts.svh
// --------------------------------------------------------------------------
// read shim constants
// queue depths, almost-full slack and the outstanding-read credit limit
// --------------------------------------------------------------------------
`ifndef SHIM_CONSTS_SVH
`define SHIM_CONSTS_SVH

// request queue holds 16 entries
`define SHIM_REQ_DEPTH_LOG2 4
`define SHIM_REQ_DEPTH      (1 << `SHIM_REQ_DEPTH_LOG2)

// response queue holds 32 entries
`define SHIM_RSP_DEPTH_LOG2 5
`define SHIM_RSP_DEPTH      (1 << `SHIM_RSP_DEPTH_LOG2)

// requests the AFU may still send after almost full rises
`define SHIM_ALMFULL_SLACK 4

// most outstanding reads allowed before almost full
// response depth less twice the slack, so late requests still find room
`define SHIM_CREDIT_LIMIT (`SHIM_RSP_DEPTH - 2 * `SHIM_ALMFULL_SLACK)

`endif

// File: source/shim_pkg.sv
// --------------------------------------------------------------------------
// read shim package
// vector types shared by the queues, the credit tracker and the top level
// --------------------------------------------------------------------------
`include "shim_consts.svh"

package shim_pkg;

   // host memory line address
   typedef logic [31:0] line_addr_t;

   // request tag, returned unchanged with the response
   typedef logic [7:0] req_tag_t;

   // narrowed line data
   typedef logic [63:0] line_data_t;

   // request queue fill count, one bit wider than the pointer
   typedef logic [`SHIM_REQ_DEPTH_LOG2:0] req_fill_t;

   // reads issued and not yet delivered to the AFU
   typedef logic [`SHIM_RSP_DEPTH_LOG2:0] outstanding_t;

endpackage

// File: source/shim_fifo.sv
// --------------------------------------------------------------------------
// shim FIFO
// single-clock show-ahead FIFO with fill count, empty and full
// --------------------------------------------------------------------------
`include "shim_consts.svh"

module shim_fifo #(
   parameter int WIDTH      = 40,
   parameter int DEPTH_LOG2 = `SHIM_REQ_DEPTH_LOG2
) (
   input  logic                  bb_clk,
   input  logic                  bb_softreset,
   input  logic                  push,
   input  logic [WIDTH-1:0]      wdata,
   input  logic                  pop,
   output logic [WIDTH-1:0]      rdata,
   output logic [DEPTH_LOG2:0]   fill,
   output logic                  empty,
   output logic                  full
);

   localparam int DEPTH = 1 << DEPTH_LOG2;

   logic [WIDTH-1:0]      mem [DEPTH];
   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2-1:0] rd_ptr;
   logic                  do_push;
   logic                  do_pop;

   // a push while full is dropped here, the caller reports it
   assign do_push = push & ~full;
   assign do_pop  = pop & ~empty;

   assign empty = (fill == '0);
   assign full  = (fill == (DEPTH_LOG2 + 1)'(DEPTH));

   // head entry is visible without a read request
   assign rdata = mem[rd_ptr];

   always_ff @(posedge bb_clk) begin
      if (do_push) begin
         mem[wr_ptr] <= wdata;
      end
   end

   always_ff @(posedge bb_clk) begin
      if (bb_softreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end
      else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
      end
   end

   // the caller only pops what it has seen at the head
   a_no_pop_when_empty : assert property (
      @(posedge bb_clk) disable iff (bb_softreset)
      pop |-> !empty
   );

endmodule

// File: source/req_queue.sv
// --------------------------------------------------------------------------
// read request queue
// buffers AFU read requests and issues them to the host in arrival order,
// holding back while the host signals almost full
// --------------------------------------------------------------------------
`include "shim_consts.svh"

module req_queue (
   input  logic                 bb_clk,
   input  logic                 bb_softreset,
   input  logic                 afu_req_valid,
   input  shim_pkg::line_addr_t afu_req_addr,
   input  shim_pkg::req_tag_t   afu_req_tag,
   input  logic                 host_almost_full,
   output logic                 host_req_valid,
   output shim_pkg::line_addr_t host_req_addr,
   output shim_pkg::req_tag_t   host_req_tag,
   output logic                 req_accepted,
   output shim_pkg::req_fill_t  req_fill,
   output logic                 req_overflow
);

   import shim_pkg::*;

   localparam int ENTRY_W = $bits(line_addr_t) + $bits(req_tag_t);
   localparam req_fill_t REQ_DEPTH = req_fill_t'(`SHIM_REQ_DEPTH);

   logic         in_valid_q;
   line_addr_t   in_addr_q;
   req_tag_t     in_tag_q;
   logic         fifo_pop;
   logic [ENTRY_W-1:0] fifo_head;
   logic         fifo_empty;
   logic         fifo_full;

   // input register stage
   always_ff @(posedge bb_clk) begin
      if (bb_softreset) begin
         in_valid_q <= 1'b0;
      end
      else begin
         in_valid_q <= afu_req_valid;
      end
      in_addr_q <= afu_req_addr;
      in_tag_q  <= afu_req_tag;
   end

   // one pulse per stored request, feeds the outstanding count
   assign req_accepted = in_valid_q & ~fifo_full;

   shim_fifo #(
      .WIDTH      (ENTRY_W),
      .DEPTH_LOG2 (`SHIM_REQ_DEPTH_LOG2)
   ) req_fifo_i (
      .bb_clk       (bb_clk),
      .bb_softreset (bb_softreset),
      .push         (in_valid_q),
      .wdata        ({in_addr_q, in_tag_q}),
      .pop          (fifo_pop),
      .rdata        (fifo_head),
      .fill         (req_fill),
      .empty        (fifo_empty),
      .full         (fifo_full)
   );

   // host almost full gates the issue edge directly, so a request never
   // lands on the edge right after a cycle of back-pressure
   assign fifo_pop = ~fifo_empty & ~host_almost_full;

   always_ff @(posedge bb_clk) begin
      if (bb_softreset) begin
         host_req_valid <= 1'b0;
         req_overflow   <= 1'b0;
      end
      else begin
         host_req_valid <= fifo_pop;
         req_overflow   <= in_valid_q & fifo_full;
      end
   end

   // payload is zero whenever nothing is issued
   always_ff @(posedge bb_clk) begin
      if (fifo_pop) begin
         {host_req_addr, host_req_tag} <= fifo_head;
      end
      else begin
         host_req_addr <= '0;
         host_req_tag  <= '0;
      end
   end

   // the queue never counts more entries than it can hold
   a_fill_within_depth : assert property (
      @(posedge bb_clk) disable iff (bb_softreset)
      req_fill <= REQ_DEPTH
   );

endmodule

// File: source/read_credit_tracker.sv
// --------------------------------------------------------------------------
// read credit tracker
// counts outstanding reads and raises almost full toward the AFU
// --------------------------------------------------------------------------
`include "shim_consts.svh"

module read_credit_tracker (
   input  logic                bb_clk,
   input  logic                bb_softreset,
   input  logic                req_accepted,
   input  logic                rsp_delivered,
   input  shim_pkg::req_fill_t req_fill,
   output logic                afu_almost_full
);

   import shim_pkg::*;

   localparam outstanding_t CREDIT_LIMIT = outstanding_t'(`SHIM_CREDIT_LIMIT);
   // leave room in the request queue for the AFU's slack
   localparam req_fill_t FILL_LIMIT =
      req_fill_t'(`SHIM_REQ_DEPTH - `SHIM_ALMFULL_SLACK);

   outstanding_t outstanding;

   always_ff @(posedge bb_clk) begin
      if (bb_softreset) begin
         outstanding <= '0;
      end
      else begin
         case ({req_accepted, rsp_delivered})
            2'b10:   outstanding <= outstanding + 1'b1;
            2'b01:   outstanding <= outstanding - 1'b1;
            default: outstanding <= outstanding;
         endcase
      end
   end

   always_ff @(posedge bb_clk) begin
      if (bb_softreset) begin
         afu_almost_full <= 1'b0;
      end
      else begin
         afu_almost_full <= (outstanding > CREDIT_LIMIT) || (req_fill >= FILL_LIMIT);
      end
   end

   // every delivered response must match an earlier accepted request
   a_no_underflow : assert property (
      @(posedge bb_clk) disable iff (bb_softreset)
      (rsp_delivered && !req_accepted) |-> (outstanding != '0)
   );

   a_no_overflow : assert property (
      @(posedge bb_clk) disable iff (bb_softreset)
      (req_accepted && !rsp_delivered) |-> (outstanding != '1)
   );

endmodule

// File: source/rsp_queue.sv
// --------------------------------------------------------------------------
// read response queue
// buffers host read responses and hands them to the AFU in order
// --------------------------------------------------------------------------
`include "shim_consts.svh"

module rsp_queue (
   input  logic                 bb_clk,
   input  logic                 bb_softreset,
   input  logic                 host_rsp_valid,
   input  shim_pkg::req_tag_t   host_rsp_tag,
   input  shim_pkg::line_data_t host_rsp_data,
   output logic                 afu_rsp_valid,
   output shim_pkg::req_tag_t   afu_rsp_tag,
   output shim_pkg::line_data_t afu_rsp_data,
   output logic                 rsp_overflow
);

   import shim_pkg::*;

   localparam int ENTRY_W = $bits(req_tag_t) + $bits(line_data_t);

   logic               in_valid_q;
   req_tag_t           in_tag_q;
   line_data_t         in_data_q;
   logic               fifo_pop;
   logic [ENTRY_W-1:0] fifo_head;
   logic               fifo_empty;
   logic               fifo_full;

   always_ff @(posedge bb_clk) begin
      if (bb_softreset) begin
         in_valid_q <= 1'b0;
      end
      else begin
         in_valid_q <= host_rsp_valid;
      end
      in_tag_q  <= host_rsp_tag;
      in_data_q <= host_rsp_data;
   end

   // fill count is not needed on this side
   shim_fifo #(
      .WIDTH      (ENTRY_W),
      .DEPTH_LOG2 (`SHIM_RSP_DEPTH_LOG2)
   ) rsp_fifo_i (
      .bb_clk       (bb_clk),
      .bb_softreset (bb_softreset),
      .push         (in_valid_q),
      .wdata        ({in_tag_q, in_data_q}),
      .pop          (fifo_pop),
      .rdata        (fifo_head),
      .fill         (),
      .empty        (fifo_empty),
      .full         (fifo_full)
   );

   // the AFU always accepts, drain one entry per cycle
   assign fifo_pop = ~fifo_empty;

   always_ff @(posedge bb_clk) begin
      if (bb_softreset) begin
         afu_rsp_valid <= 1'b0;
         rsp_overflow  <= 1'b0;
      end
      else begin
         afu_rsp_valid <= fifo_pop;
         rsp_overflow  <= in_valid_q & fifo_full;
      end
   end

   always_ff @(posedge bb_clk) begin
      if (fifo_pop) begin
         {afu_rsp_tag, afu_rsp_data} <= fifo_head;
      end
      else begin
         afu_rsp_tag  <= '0;
         afu_rsp_data <= '0;
      end
   end

endmodule

// File: source/read_shim_top.sv
// --------------------------------------------------------------------------
// read shim top level
// connects the request queue, the response queue and the credit tracker
// between the AFU and the host memory port
// --------------------------------------------------------------------------
module read_shim_top (
   input  logic                 bb_clk,
   input  logic                 bb_softreset,
   // AFU side
   input  logic                 afu_req_valid,
   input  shim_pkg::line_addr_t afu_req_addr,
   input  shim_pkg::req_tag_t   afu_req_tag,
   output logic                 afu_almost_full,
   output logic                 afu_rsp_valid,
   output shim_pkg::req_tag_t   afu_rsp_tag,
   output shim_pkg::line_data_t afu_rsp_data,
   // host side
   output logic                 host_req_valid,
   output shim_pkg::line_addr_t host_req_addr,
   output shim_pkg::req_tag_t   host_req_tag,
   input  logic                 host_almost_full,
   input  logic                 host_rsp_valid,
   input  shim_pkg::req_tag_t   host_rsp_tag,
   input  shim_pkg::line_data_t host_rsp_data,
   // bit 0 request overflow, bit 1 response overflow
   output logic [1:0]           shim_error
);

   import shim_pkg::*;

   logic      req_accepted;
   req_fill_t req_fill;
   logic      req_overflow;
   logic      rsp_overflow;

   req_queue req_queue_i (
      .bb_clk           (bb_clk),
      .bb_softreset     (bb_softreset),
      .afu_req_valid    (afu_req_valid),
      .afu_req_addr     (afu_req_addr),
      .afu_req_tag      (afu_req_tag),
      .host_almost_full (host_almost_full),
      .host_req_valid   (host_req_valid),
      .host_req_addr    (host_req_addr),
      .host_req_tag     (host_req_tag),
      .req_accepted     (req_accepted),
      .req_fill         (req_fill),
      .req_overflow     (req_overflow)
   );

   read_credit_tracker read_credit_tracker_i (
      .bb_clk          (bb_clk),
      .bb_softreset    (bb_softreset),
      .req_accepted    (req_accepted),
      .rsp_delivered   (afu_rsp_valid),
      .req_fill        (req_fill),
      .afu_almost_full (afu_almost_full)
   );

   rsp_queue rsp_queue_i (
      .bb_clk         (bb_clk),
      .bb_softreset   (bb_softreset),
      .host_rsp_valid (host_rsp_valid),
      .host_rsp_tag   (host_rsp_tag),
      .host_rsp_data  (host_rsp_data),
      .afu_rsp_valid  (afu_rsp_valid),
      .afu_rsp_tag    (afu_rsp_tag),
      .afu_rsp_data   (afu_rsp_data),
      .rsp_overflow   (rsp_overflow)
   );

   assign shim_error = {rsp_overflow, req_overflow};

endmodule

// File: bench/read_shim_tb.sv
// --------------------------------------------------------------------------
// read shim testbench
// table-driven AFU traffic, a host model with back-pressure and delayed
// responses, and a cycle model of the almost-full and overflow outputs
// --------------------------------------------------------------------------
`include "shim_consts.svh"

module read_shim_tb;

   import shim_pkg::*;

   localparam int REQ_DEPTH    = `SHIM_REQ_DEPTH;
   localparam int FILL_LIMIT   = `SHIM_REQ_DEPTH - `SHIM_ALMFULL_SLACK;
   localparam int CREDIT_LIMIT = `SHIM_CREDIT_LIMIT;
   // edges from the sampling edge to the output
   localparam int REQ_LAT      = 2;
   localparam int RSP_LAT      = 2;
   localparam int ROW_TIMEOUT  = 400;
   localparam line_data_t RSP_MASK = 64'h5a5a_0000_0000_a5a5;

   typedef struct {
      int   n_req;
      int   hafull_pat;
      int   hafull_len;
      int   rsp_delay;
      logic honor_afull;
      int   n_drop;
      logic expect_afull;
   } row_t;

   logic       bb_clk;
   logic       bb_softreset;
   logic       afu_req_valid;
   line_addr_t afu_req_addr;
   req_tag_t   afu_req_tag;
   logic       afu_almost_full;
   logic       afu_rsp_valid;
   req_tag_t   afu_rsp_tag;
   line_data_t afu_rsp_data;
   logic       host_req_valid;
   line_addr_t host_req_addr;
   req_tag_t   host_req_tag;
   logic       host_almost_full;
   logic       host_rsp_valid;
   req_tag_t   host_rsp_tag;
   line_data_t host_rsp_data;
   logic [1:0] shim_error;

   row_t       rows [6];
   int         cyc;
   int         sent_cnt;
   int         drop_cnt;
   int         out_cnt;
   int         fill_cnt;
   logic       afull_seen;
   logic       rsp_seen_prev;
   logic       hafull_prev;
   logic [31:0] rand_state;
   req_tag_t   tag_ctr;

   // requests driven one and two cycles ago, still in the input register path
   logic       d1_valid;
   logic       d2_valid;
   line_addr_t d1_addr;
   line_addr_t d2_addr;
   req_tag_t   d1_tag;
   req_tag_t   d2_tag;
   int         d1_tick;
   int         d2_tick;

   // accepted requests not yet seen at the host
   line_addr_t exp_req_addr [$];
   req_tag_t   exp_req_tag [$];
   int         exp_req_tick [$];
   // host responses waiting for their delay
   req_tag_t   hp_tag [$];
   line_data_t hp_data [$];
   int         hp_due [$];
   // responses driven by the host, due at the AFU
   req_tag_t   exp_rsp_tag [$];
   line_data_t exp_rsp_data [$];
   int         exp_rsp_tick [$];

   read_shim_top dut_i (
      .bb_clk           (bb_clk),
      .bb_softreset     (bb_softreset),
      .afu_req_valid    (afu_req_valid),
      .afu_req_addr     (afu_req_addr),
      .afu_req_tag      (afu_req_tag),
      .afu_almost_full  (afu_almost_full),
      .afu_rsp_valid    (afu_rsp_valid),
      .afu_rsp_tag      (afu_rsp_tag),
      .afu_rsp_data     (afu_rsp_data),
      .host_req_valid   (host_req_valid),
      .host_req_addr    (host_req_addr),
      .host_req_tag     (host_req_tag),
      .host_almost_full (host_almost_full),
      .host_rsp_valid   (host_rsp_valid),
      .host_rsp_tag     (host_rsp_tag),
      .host_rsp_data    (host_rsp_data),
      .shim_error       (shim_error)
   );

   always #4 bb_clk = ~bb_clk;

   function automatic logic [31:0] next_rand(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic row_t make_row(input int n_req, input int pat, input int len,
                                     input int delay, input logic honor, input int n_drop,
                                     input logic afull);
      row_t r;
      r.n_req        = n_req;
      r.hafull_pat   = pat;
      r.hafull_len   = len;
      r.rsp_delay    = delay;
      r.honor_afull  = honor;
      r.n_drop       = n_drop;
      r.expect_afull = afull;
      return r;
   endfunction

   task automatic stop_run();
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic report_problem(input string what);
      $display("error at %0t: %s", $time, what);
      stop_run();
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_req(input line_addr_t got_addr, input req_tag_t got_tag,
                            input line_addr_t exp_addr, input req_tag_t exp_tag);
      if (got_addr !== exp_addr || got_tag !== exp_tag) begin
         $display("mismatch at %0t: host_req_addr/tag got %h/%h expected %h/%h",
                  $time, got_addr, got_tag, exp_addr, exp_tag);
         stop_run();
      end
   endtask

   task automatic check_rsp(input req_tag_t got_tag, input line_data_t got_data,
                            input req_tag_t exp_tag, input line_data_t exp_data);
      if (got_tag !== exp_tag || got_data !== exp_data) begin
         $display("mismatch at %0t: afu_rsp_tag/data got %h/%h expected %h/%h",
                  $time, got_tag, got_data, exp_tag, exp_data);
         stop_run();
      end
   endtask

   // inputs change one time unit after the edge, outputs are stable there
   task automatic advance_cycle();
      @(posedge bb_clk);
      #1;
      cyc++;
   endtask

   task automatic run_cycle(input row_t r, input int row_tick);
      logic       exp_afull;
      logic       exp_drop;
      logic       want_rsp;
      logic       hafull_now;
      int         min_tick;
      advance_cycle();
      // counts still hold their values after the previous edge
      exp_afull = (out_cnt > CREDIT_LIMIT) || (fill_cnt >= FILL_LIMIT);
      check_flag("afu_almost_full", afu_almost_full, exp_afull);
      afull_seen = afull_seen | afu_almost_full;
      // push edge for the request driven two cycles ago
      exp_drop = d2_valid && (fill_cnt == REQ_DEPTH);
      check_flag("shim_error[0]", shim_error[0], exp_drop);
      check_flag("shim_error[1]", shim_error[1], 1'b0);
      if (exp_drop) begin
         drop_cnt++;
      end

      if (host_req_valid) begin
         if (hafull_prev) begin
            report_problem("host request issued after a cycle of host almost full");
         end
         if (exp_req_addr.size() == 0) begin
            report_problem("host request issued with no request queued");
         end
         check_req(host_req_addr, host_req_tag, exp_req_addr[0], exp_req_tag[0]);
         min_tick = exp_req_tick[0] + 1 + REQ_LAT;
         if (cyc < min_tick) begin
            report_problem("host request issued before the request path latency");
         end
         else if (r.hafull_pat == 0 && cyc != min_tick) begin
            report_problem("host request late without host back-pressure");
         end
         hp_tag.push_back(exp_req_tag[0]);
         hp_data.push_back(line_data_t'(exp_req_addr[0]) ^ RSP_MASK);
         hp_due.push_back(cyc + r.rsp_delay);
         void'(exp_req_addr.pop_front());
         void'(exp_req_tag.pop_front());
         void'(exp_req_tick.pop_front());
         fill_cnt--;
      end

      want_rsp = (exp_rsp_tick.size() > 0) && (exp_rsp_tick[0] == cyc);
      check_flag("afu_rsp_valid", afu_rsp_valid, want_rsp);
      if (want_rsp) begin
         check_rsp(afu_rsp_tag, afu_rsp_data, exp_rsp_tag[0], exp_rsp_data[0]);
         void'(exp_rsp_tag.pop_front());
         void'(exp_rsp_data.pop_front());
         void'(exp_rsp_tick.pop_front());
      end
      else begin
         // response outputs are zero between responses
         check_rsp(afu_rsp_tag, afu_rsp_data, '0, '0);
      end

      if (d2_valid && !exp_drop) begin
         exp_req_addr.push_back(d2_addr);
         exp_req_tag.push_back(d2_tag);
         exp_req_tick.push_back(d2_tick);
         fill_cnt++;
         out_cnt++;
      end
      if (rsp_seen_prev) begin
         out_cnt--;
      end
      rsp_seen_prev = afu_rsp_valid;

      // host side for the next cycle
      hafull_now = (row_tick < r.hafull_len) ? r.hafull_pat[row_tick % 8] : 1'b0;
      host_almost_full = hafull_now;
      hafull_prev      = hafull_now;
      if (hp_due.size() > 0 && hp_due[0] <= cyc) begin
         host_rsp_valid = 1'b1;
         host_rsp_tag   = hp_tag[0];
         host_rsp_data  = hp_data[0];
         exp_rsp_tag.push_back(hp_tag[0]);
         exp_rsp_data.push_back(hp_data[0]);
         exp_rsp_tick.push_back(cyc + 1 + RSP_LAT);
         void'(hp_tag.pop_front());
         void'(hp_data.pop_front());
         void'(hp_due.pop_front());
      end
      else begin
         host_rsp_valid = 1'b0;
         host_rsp_tag   = '0;
         host_rsp_data  = '0;
      end

      // AFU side for the next cycle
      d2_valid = d1_valid;
      d2_addr  = d1_addr;
      d2_tag   = d1_tag;
      d2_tick  = d1_tick;
      if (sent_cnt < r.n_req && !(r.honor_afull && afu_almost_full)) begin
         rand_state    = next_rand(rand_state);
         afu_req_valid = 1'b1;
         afu_req_addr  = rand_state;
         afu_req_tag   = tag_ctr;
         d1_valid      = 1'b1;
         d1_addr       = rand_state;
         d1_tag        = tag_ctr;
         d1_tick       = cyc;
         tag_ctr       = tag_ctr + 8'd1;
         sent_cnt++;
      end
      else begin
         afu_req_valid = 1'b0;
         d1_valid      = 1'b0;
      end
   endtask

   function automatic logic row_finished(input row_t r, input int row_tick);
      return (sent_cnt == r.n_req) && !d1_valid && !d2_valid
         && (exp_req_addr.size() == 0) && (hp_due.size() == 0)
         && (exp_rsp_tick.size() == 0) && (out_cnt == 0) && (fill_cnt == 0)
         && (row_tick >= r.hafull_len);
   endfunction

   initial begin
      int row_tick;
      bb_clk           = 1'b0;
      bb_softreset     = 1'b1;
      afu_req_valid    = 1'b0;
      afu_req_addr     = '0;
      afu_req_tag      = '0;
      host_almost_full = 1'b0;
      host_rsp_valid   = 1'b0;
      host_rsp_tag     = '0;
      host_rsp_data    = '0;
      cyc              = 0;
      out_cnt          = 0;
      fill_cnt         = 0;
      rsp_seen_prev    = 1'b0;
      hafull_prev      = 1'b0;
      d1_valid         = 1'b0;
      d2_valid         = 1'b0;
      rand_state       = 32'hb2b6d61e;
      tag_ctr          = '0;

      // requests, host almost-full pattern and length, response delay,
      // AFU honors almost full, expected drops, almost full expected
      rows[0] = make_row(1, 'h00, 0, 2, 1'b1, 0, 1'b0);
      rows[1] = make_row(12, 'h00, 0, 3, 1'b1, 0, 1'b0);
      rows[2] = make_row(10, 'b1011_0110, 30, 1, 1'b1, 0, 1'b0);
      rows[3] = make_row(40, 'h00, 0, 40, 1'b1, 0, 1'b1);
      rows[4] = make_row(14, 'hff, 30, 0, 1'b1, 0, 1'b1);
      rows[5] = make_row(20, 'hff, 40, 0, 1'b0, 4, 1'b1);

      for (int i = 0; i < 10; i++) begin
         advance_cycle();
      end
      bb_softreset = 1'b0;
      advance_cycle();
      check_flag("host_req_valid", host_req_valid, 1'b0);
      check_flag("afu_rsp_valid", afu_rsp_valid, 1'b0);
      check_flag("afu_almost_full", afu_almost_full, 1'b0);
      check_flag("shim_error[0]", shim_error[0], 1'b0);
      check_flag("shim_error[1]", shim_error[1], 1'b0);

      foreach (rows[i]) begin
         row_tick   = 0;
         sent_cnt   = 0;
         drop_cnt   = 0;
         afull_seen = 1'b0;
         do begin
            run_cycle(rows[i], row_tick);
            row_tick++;
            if (row_tick > ROW_TIMEOUT) begin
               report_problem($sformatf("row %0d did not drain before the timeout", i));
            end
         end while (!row_finished(rows[i], row_tick));
         // almost full drops one edge after the counts reach zero
         run_cycle(rows[i], row_tick);
         check_flag("afu_almost_full", afu_almost_full, 1'b0);
         if (drop_cnt != rows[i].n_drop) begin
            report_problem($sformatf("row %0d dropped %0d requests instead of %0d",
                                     i, drop_cnt, rows[i].n_drop));
         end
         if (rows[i].expect_afull && !afull_seen) begin
            report_problem($sformatf("row %0d never raised afu_almost_full", i));
         end
      end

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

// File: flist.f
+incdir+source
source/shim_pkg.sv
source/shim_fifo.sv
source/req_queue.sv
source/read_credit_tracker.sv
source/rsp_queue.sv
source/read_shim_top.sv
bench/read_shim_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the read shim testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module read_shim_tb -f flist.f

./obj_dir/Vread_shim_tb 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
   echo "run failed, see sim.log"
   exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
   echo "run ended without a result, see sim.log"
   exit 1
fi
echo "run passed"
